// File: Bender.yml
package:
  name: beam_transmitter

sources:
  - files:
      - common/beam_pkg.sv
      - common/scan_pkg.sv
  - files:
      - source/scan_control.sv
      - delay_calc/delay_stepper.sv
      - delay_calc/delay_collector.sv
      - source/tx_countdown.sv
      - source/beam_transmitter.sv
  - target: test
    files:
      - tests/tb_beam_transmitter.sv

// File: common/beam_pkg.sv
package beam_pkg;

    // Array geometry
    localparam int NUM_ELEMENTS   = 64;
    localparam int CENTER_ELEMENT = 31;     // Top of the low half

    // Fixed point delays
    localparam int FRAC_BITS  = 4;
    localparam int DELAY_BITS = 18;         // 14 integer + 4 fraction
    localparam int SPAN_BITS  = DELAY_BITS - FRAC_BITS;

    localparam int RADIUS_BITS = 8;
    localparam int ANGLE_BITS  = 8;
    localparam int IDX_BITS    = 6;

    // Focal radius as given on the input
    typedef logic [RADIUS_BITS-1:0] radius_t;

    // Steering step per element in delay fraction units
    typedef logic signed [ANGLE_BITS-1:0] angle_t;

    typedef logic [DELAY_BITS-1:0] delay_t;

    // Element number, or step count away from the center
    typedef logic [IDX_BITS-1:0] elem_idx_t;

    // Whole samples of the countdown
    typedef logic [SPAN_BITS-1:0] span_t;

endpackage

// File: common/scan_pkg.sv
package scan_pkg;

    localparam int POINT_BITS = 13;

    // One whole sample in delay units
    localparam int POINT_STEP = 1 << beam_pkg::FRAC_BITS;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        CALC,
        TRANSMIT,
        LOAD_NEXT
    } scan_state_t;

    typedef logic [POINT_BITS-1:0] point_cnt_t;

endpackage

// File: delay_calc/delay_collector.sv
module delay_collector (
    input  logic                clk,
    input  logic                rst,
    input  logic                calc_start,
    input  beam_pkg::delay_t    base_delay,
    input  logic                up_valid,
    input  beam_pkg::elem_idx_t up_index,
    input  beam_pkg::delay_t    up_delay,
    input  logic                down_valid,
    input  beam_pkg::elem_idx_t down_index,
    input  beam_pkg::delay_t    down_delay,
    output beam_pkg::delay_t    delay_array [beam_pkg::NUM_ELEMENTS],
    output beam_pkg::delay_t    delay_min,
    output beam_pkg::delay_t    delay_max
);

    beam_pkg::elem_idx_t up_slot;
    beam_pkg::elem_idx_t down_slot;
    beam_pkg::delay_t    min_next;
    beam_pkg::delay_t    max_next;

    // Step k lands k elements either side of the center
    assign up_slot   = beam_pkg::elem_idx_t'(beam_pkg::CENTER_ELEMENT) + up_index;
    assign down_slot = beam_pkg::elem_idx_t'(beam_pkg::CENTER_ELEMENT) - down_index;

    always_comb begin
        min_next = delay_min;
        max_next = delay_max;

        if (up_valid) begin
            if (up_delay < min_next)
                min_next = up_delay;
            if (up_delay > max_next)
                max_next = up_delay;
        end

        if (down_valid) begin
            if (down_delay < min_next)
                min_next = down_delay;
            if (down_delay > max_next)
                max_next = down_delay;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            delay_min <= '0;
            delay_max <= '0;
        end else if (calc_start) begin
            delay_min <= base_delay;    // Center element seeds both bounds
            delay_max <= base_delay;
        end else begin
            delay_min <= min_next;
            delay_max <= max_next;
        end
    end

    always_ff @(posedge clk) begin
        if (calc_start)
            delay_array[beam_pkg::CENTER_ELEMENT] <= base_delay;
        if (up_valid)
            delay_array[up_slot] <= up_delay;
        if (down_valid)
            delay_array[down_slot] <= down_delay;
    end

    // Down side is one element shorter, so it never runs alone
    a_down_within_up: assert property (
        @(posedge clk) disable iff (rst)
        down_valid |-> up_valid
    );

endmodule

// File: delay_calc/delay_stepper.sv
module delay_stepper #(
    parameter bit SUBTRACT = 1'b0,
    parameter int STEPS    = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                calc_start,
    input  beam_pkg::delay_t    base_delay,
    input  beam_pkg::angle_t    step,
    output logic                valid,
    output logic                last,
    output beam_pkg::elem_idx_t index,
    output beam_pkg::delay_t    delay
);

    // Two guard bits to catch wrap in either direction
    logic signed [beam_pkg::DELAY_BITS+1:0] step_ext;
    logic signed [beam_pkg::DELAY_BITS+1:0] operand;
    logic signed [beam_pkg::DELAY_BITS+1:0] next_sum;
    logic                                   advance;

    assign step_ext = step;     // Sign-extended
    assign operand  = calc_start ? {2'b00, base_delay} : {2'b00, delay};
    assign next_sum = SUBTRACT ? operand - step_ext : operand + step_ext;

    assign advance = calc_start || (valid && !last);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            last  <= 1'b0;
            index <= '0;
        end else if (calc_start) begin
            valid <= 1'b1;
            last  <= (STEPS == 1);
            index <= beam_pkg::elem_idx_t'(1);
        end else if (valid && !last) begin
            index <= index + 1'b1;
            last  <= ((index + 1) == STEPS);
        end else begin
            valid <= 1'b0;
            last  <= 1'b0;
        end
    end

    // Accumulator
    always_ff @(posedge clk) begin
        if (advance)
            delay <= next_sum[beam_pkg::DELAY_BITS-1:0];
    end

    a_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        advance |-> (next_sum[beam_pkg::DELAY_BITS+1:beam_pkg::DELAY_BITS] == 2'b00)
    );

endmodule

// File: source/beam_transmitter.sv
module beam_transmitter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              initiate,
    input  beam_pkg::radius_t                 r_0,
    input  beam_pkg::angle_t                  angle,
    input  scan_pkg::point_cnt_t              num_points,
    output logic [beam_pkg::NUM_ELEMENTS-1:0] tx_array,
    output logic                              done
);

    logic                calc_start;
    beam_pkg::delay_t    base_delay;
    beam_pkg::angle_t    step;
    logic                tx_start;
    logic                tx_done;

    logic                up_valid;
    logic                up_last;
    beam_pkg::elem_idx_t up_index;
    beam_pkg::delay_t    up_delay;

    logic                down_valid;
    beam_pkg::elem_idx_t down_index;
    beam_pkg::delay_t    down_delay;

    beam_pkg::delay_t    delay_array [beam_pkg::NUM_ELEMENTS];
    beam_pkg::delay_t    delay_min;
    beam_pkg::delay_t    delay_max;

    scan_control u_scan_control (
        .clk        (clk),
        .rst        (rst),
        .initiate   (initiate),
        .r_0        (r_0),
        .angle      (angle),
        .num_points (num_points),
        .up_last    (up_last),
        .tx_done    (tx_done),
        .calc_start (calc_start),
        .base_delay (base_delay),
        .step       (step),
        .tx_start   (tx_start),
        .done       (done)
    );

    // Elements 32..63
    delay_stepper #(.SUBTRACT(1'b0), .STEPS(32)) up_stepper (
        .clk        (clk),
        .rst        (rst),
        .calc_start (calc_start),
        .base_delay (base_delay),
        .step       (step),
        .valid      (up_valid),
        .last       (up_last),
        .index      (up_index),
        .delay      (up_delay)
    );

    // Elements 30..0 finish a cycle before the up side
    delay_stepper #(.SUBTRACT(1'b1), .STEPS(31)) down_stepper (
        .clk        (clk),
        .rst        (rst),
        .calc_start (calc_start),
        .base_delay (base_delay),
        .step       (step),
        .valid      (down_valid),
        .last       (),
        .index      (down_index),
        .delay      (down_delay)
    );

    delay_collector u_delay_collector (
        .clk         (clk),
        .rst         (rst),
        .calc_start  (calc_start),
        .base_delay  (base_delay),
        .up_valid    (up_valid),
        .up_index    (up_index),
        .up_delay    (up_delay),
        .down_valid  (down_valid),
        .down_index  (down_index),
        .down_delay  (down_delay),
        .delay_array (delay_array),
        .delay_min   (delay_min),
        .delay_max   (delay_max)
    );

    tx_countdown u_tx_countdown (
        .clk         (clk),
        .rst         (rst),
        .tx_start    (tx_start),
        .delay_array (delay_array),
        .delay_min   (delay_min),
        .delay_max   (delay_max),
        .tx_array    (tx_array),
        .tx_done     (tx_done)
    );

endmodule

// File: source/scan_control.sv
module scan_control (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 initiate,
    input  beam_pkg::radius_t    r_0,
    input  beam_pkg::angle_t     angle,
    input  scan_pkg::point_cnt_t num_points,
    input  logic                 up_last,
    input  logic                 tx_done,
    output logic                 calc_start,
    output beam_pkg::delay_t     base_delay,
    output beam_pkg::angle_t     step,
    output logic                 tx_start,
    output logic                 done
);

    scan_pkg::scan_state_t state;

    beam_pkg::radius_t    r_0_q;
    scan_pkg::point_cnt_t num_points_q;
    scan_pkg::point_cnt_t point_cnt;
    logic                 up_last_q;
    logic                 last_point;

    // N0 scaled by 4 so the 1/64 term keeps its bits until the end
    logic [beam_pkg::DELAY_BITS+1:0] n0_x4;
    logic [beam_pkg::DELAY_BITS+1:0] r_0_wide;

    assign r_0_wide = {{(beam_pkg::DELAY_BITS + 2 - beam_pkg::RADIUS_BITS){1'b0}}, r_0_q};

    // 16 + 1/4 - 1/64 samples per radius unit
    assign n0_x4 = (r_0_wide << (beam_pkg::FRAC_BITS + 6))
                 + (r_0_wide << beam_pkg::FRAC_BITS)
                 - r_0_wide;

    assign last_point = (point_cnt == num_points_q);

    assign done = (state == scan_pkg::TRANSMIT) && tx_done && last_point;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= scan_pkg::IDLE;
            calc_start <= 1'b0;
            tx_start   <= 1'b0;
            up_last_q  <= 1'b0;
            point_cnt  <= '0;
        end else begin
            calc_start <= 1'b0;
            tx_start   <= 1'b0;
            up_last_q  <= up_last;

            case (state)
                scan_pkg::IDLE: begin
                    if (initiate) begin
                        state     <= scan_pkg::LOAD;
                        point_cnt <= scan_pkg::point_cnt_t'(1);
                    end
                end
                scan_pkg::LOAD: begin
                    state      <= scan_pkg::CALC;
                    calc_start <= 1'b1;
                end
                scan_pkg::CALC: begin
                    // Last up delay lands in the collector one cycle before this
                    if (up_last_q) begin
                        state    <= scan_pkg::TRANSMIT;
                        tx_start <= 1'b1;
                    end
                end
                scan_pkg::TRANSMIT: begin
                    if (tx_done) begin
                        if (last_point)
                            state <= scan_pkg::IDLE;
                        else
                            state <= scan_pkg::LOAD_NEXT;
                    end
                end
                scan_pkg::LOAD_NEXT: begin
                    state      <= scan_pkg::CALC;
                    calc_start <= 1'b1;
                    point_cnt  <= point_cnt + 1'b1;
                end
                default: state <= scan_pkg::IDLE;
            endcase
        end
    end

    // Scan parameters and the center delay
    always_ff @(posedge clk) begin
        if (state == scan_pkg::IDLE && initiate) begin
            r_0_q        <= r_0;
            step         <= angle;
            num_points_q <= num_points;
        end

        if (state == scan_pkg::LOAD)
            base_delay <= n0_x4[beam_pkg::DELAY_BITS+1:2];
        else if (state == scan_pkg::LOAD_NEXT)
            base_delay <= base_delay + beam_pkg::delay_t'(scan_pkg::POINT_STEP);
    end

    a_points_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        (state == scan_pkg::IDLE && initiate) |-> (num_points != '0)
    );

endmodule

// File: source/tx_countdown.sv
module tx_countdown (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            tx_start,
    input  beam_pkg::delay_t                delay_array [beam_pkg::NUM_ELEMENTS],
    input  beam_pkg::delay_t                delay_min,
    input  beam_pkg::delay_t                delay_max,
    output logic [beam_pkg::NUM_ELEMENTS-1:0] tx_array,
    output logic                            tx_done
);

    beam_pkg::span_t offset_next [beam_pkg::NUM_ELEMENTS];
    beam_pkg::span_t offset      [beam_pkg::NUM_ELEMENTS];
    beam_pkg::span_t span;
    beam_pkg::span_t count;
    logic            running;

    // Latest delay gets offset zero
    always_comb begin
        for (int i = 0; i < beam_pkg::NUM_ELEMENTS; i++)
            offset_next[i] = beam_pkg::span_t'((delay_max - delay_array[i]) >> beam_pkg::FRAC_BITS);
    end

    always_ff @(posedge clk) begin
        if (tx_start) begin
            offset <= offset_next;
            span   <= beam_pkg::span_t'((delay_max - delay_min) >> beam_pkg::FRAC_BITS);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
        end else if (tx_start) begin
            running <= 1'b1;
            count   <= '0;
        end else if (running) begin
            if (count == span)
                running <= 1'b0;
            else
                count <= count + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < beam_pkg::NUM_ELEMENTS; i++)
            tx_array[i] = running && (count == offset[i]);
    end

    assign tx_done = running && (count == span);   // Same cycle as the earliest element

    a_no_restart: assert property (
        @(posedge clk) disable iff (rst)
        tx_start |-> !running
    );

endmodule

// File: tb.f
common/beam_pkg.sv
common/scan_pkg.sv
source/scan_control.sv
delay_calc/delay_stepper.sv
delay_calc/delay_collector.sv
source/tx_countdown.sv
source/beam_transmitter.sv
tests/tb_beam_transmitter.sv

// File: tests/tb_beam_transmitter.sv
module tb_beam_transmitter;

    localparam int NUM         = beam_pkg::NUM_ELEMENTS;
    localparam int START_LIMIT = 200;   // Cycles from initiate to the first pulse
    localparam int BURST_LIMIT = 1000;  // Longest possible span plus margin

    logic                                clk;
    logic                                rst;
    logic                                initiate;
    beam_pkg::radius_t                   r_0;
    beam_pkg::angle_t                    angle;
    scan_pkg::point_cnt_t                num_points;
    logic [beam_pkg::NUM_ELEMENTS-1:0]   tx_array;
    logic                                done;

    int seed = 27764;
    int done_count;
    int exp_off  [NUM];
    int min_off;
    int fire_cnt [NUM];
    int fire_rel [NUM];

    beam_transmitter DUT (
        .clk        (clk),
        .rst        (rst),
        .initiate   (initiate),
        .r_0        (r_0),
        .angle      (angle),
        .num_points (num_points),
        .tx_array   (tx_array),
        .done       (done)
    );

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (!rst && done)
            done_count++;
    end

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic signed [63:0] actual,
                         input logic signed [63:0] expected);
        if (actual !== expected)
            abort($sformatf("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                            $time, name, actual, expected));
    endtask

    // Delays from the linear steering rule and offsets counted from the latest delay
    function automatic void build_model(input int r, input int a);
        int n0;
        int d [NUM];
        int dmax;
        n0   = (r * 1039) / 4;      // 16.234375 samples x 16 fraction units
        dmax = 0;
        for (int i = 0; i < NUM; i++) begin
            d[i] = n0 + (i - beam_pkg::CENTER_ELEMENT) * a;
            if (d[i] > dmax)
                dmax = d[i];
        end
        min_off = BURST_LIMIT;
        for (int i = 0; i < NUM; i++) begin
            exp_off[i] = (dmax - d[i]) >> beam_pkg::FRAC_BITS;
            if (exp_off[i] < min_off)
                min_off = exp_off[i];
        end
    endfunction

    task automatic start_scan(input int r, input int a, input int points);
        @(posedge clk);
        r_0        <= beam_pkg::radius_t'(r);
        angle      <= beam_pkg::angle_t'(a);
        num_points <= scan_pkg::point_cnt_t'(points);
        initiate   <= 1'b1;
        @(posedge clk);
        initiate   <= 1'b0;
    endtask

    // Records each element's first pulse relative to the first pulse of the burst
    task automatic capture_burst(input bit last_burst);
        int waited;
        int rel;
        int fired;
        waited = 0;
        rel    = 0;
        fired  = 0;
        for (int i = 0; i < NUM; i++) begin
            fire_cnt[i] = 0;
            fire_rel[i] = -1;
        end
        @(negedge clk);
        while (tx_array == '0) begin
            check("done", done, 0);
            if (waited == START_LIMIT)
                abort("No transmit burst started within the time limit");
            waited++;
            @(negedge clk);
        end
        while (fired < NUM) begin
            for (int i = 0; i < NUM; i++) begin
                if (tx_array[i]) begin
                    if (fire_cnt[i] == 0) begin
                        fire_rel[i] = rel;
                        fired++;
                    end
                    fire_cnt[i]++;
                end
            end
            if (fired < NUM) begin
                check("done", done, 0);
                if (rel == BURST_LIMIT)
                    abort("Transmit burst ended before every element fired");
                rel++;
                @(negedge clk);
            end
        end
        check("done", done, last_burst);    // Together with the final pulse
        @(negedge clk);
        check("tx_array", tx_array, 0);
    endtask

    task automatic run_scan(input int r, input int a, input int points);
        build_model(r, a);
        done_count = 0;
        start_scan(r, a, points);
        for (int p = 0; p < points; p++) begin
            capture_burst(p == points - 1);
            for (int i = 0; i < NUM; i++) begin
                check($sformatf("fire count of element %0d", i), fire_cnt[i], 1);
                check($sformatf("fire offset of element %0d", i), fire_rel[i],
                      exp_off[i] - min_off);
            end
        end
        check("done pulse count", done_count, 1);
    endtask

    task automatic test_idle_quiet();
        repeat (40) begin
            @(negedge clk);
            check("tx_array", tx_array, 0);
            check("done", done, 0);
        end
    endtask

    task automatic test_zero_angle();
        run_scan(100, 0, 1);
        for (int i = 0; i < NUM; i++)
            check($sformatf("fire offset of element %0d", i), fire_rel[i], 0);
    endtask

    // Largest delay fires first
    task automatic test_positive_angle();
        run_scan(200, 20, 1);
        check("fire offset of element 63", fire_rel[63], 0);
        check("fire offset of element 0", fire_rel[0], exp_off[0]);
    endtask

    task automatic test_negative_angle();
        run_scan(200, -20, 1);
        check("fire offset of element 0", fire_rel[0], 0);
        check("fire offset of element 63", fire_rel[63], exp_off[63]);
    endtask

    task automatic test_multi_point();
        run_scan(150, 37, 3);
    endtask

    task automatic test_random_scans();
        int rnd;
        int r;
        beam_pkg::angle_t ang;
        repeat (5) begin
            rnd = $random(seed);
            r   = 128 + (rnd & 127);
            rnd = $random(seed);
            ang = rnd[7:0];
            run_scan(r, ang, 1);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        initiate   = 1'b0;
        r_0        = '0;
        angle      = '0;
        num_points = '0;
        done_count = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_idle_quiet();
        test_zero_angle();
        test_positive_angle();
        test_negative_angle();
        test_multi_point();
        test_random_scans();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
